// ==== source/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

   // Shared memory bus widths

   // One bus word
   localparam int bus_w = 32;

   // One cache line, four bus words
   localparam int line_w = 128;

   // Line address from either cache
   localparam int addr_w = 16;

   // Words moved per line transfer
   localparam int beats = line_w / bus_w;

   // Command on the shared bus
   // Held by the master from the address phase
   // until the last acknowledged beat
   typedef enum logic [1:0] {
      bus_idle  = 2'd0,
      bus_read  = 2'd1,
      bus_write = 2'd2
   } bus_cmd_e;

endpackage

`default_nettype wire

// ==== source/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter
   import bus_pkg::*;
(
   input  logic              bus_clk,
   input  logic              rst_n,
   // Bit 0 is the icache port, bit 1 the dcache port
   input  logic [1:0]        br,
   output logic [1:0]        bg,
   input  bus_cmd_e          ic_cmd,
   input  bus_cmd_e          dc_cmd,
   input  logic [addr_w-1:0] ic_addr,
   input  logic [addr_w-1:0] dc_addr,
   input  logic [bus_w-1:0]  ic_wdata,
   input  logic [bus_w-1:0]  dc_wdata,
   output bus_cmd_e          bus_cmd,
   output logic [addr_w-1:0] bus_addr,
   output logic [bus_w-1:0]  bus_wdata
);

   // Set when the dcache port held the bus last
   logic last_dc;
   // Current owner still requesting
   logic owner_req;

   assign owner_req = |(bg & br);

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         bg      <= 2'b00;
         // icache wins the first contention
         last_dc <= 1'b1;
      end else if (!owner_req) begin
         // Bus free or owner just let go
         if (br[0] && (!br[1] || last_dc)) begin
            bg      <= 2'b01;
            last_dc <= 1'b0;
         end else if (br[1]) begin
            bg      <= 2'b10;
            last_dc <= 1'b1;
         end else begin
            bg <= 2'b00;
         end
      end
   end

   // Drive the shared bus from the owner
   always_comb begin
      case (bg)
         2'b01: begin
            bus_cmd   = ic_cmd;
            bus_addr  = ic_addr;
            bus_wdata = ic_wdata;
         end
         2'b10: begin
            bus_cmd   = dc_cmd;
            bus_addr  = dc_addr;
            bus_wdata = dc_wdata;
         end
         default: begin
            // nobody owns the bus
            bus_cmd   = bus_idle;
            bus_addr  = '0;
            bus_wdata = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== source/cache_bus_port.sv ====
`default_nettype none

module cache_bus_port
   import bus_pkg::*;
(
   input  logic              bus_clk,
   input  logic              rst_n,
   // Cache side
   input  logic              en,
   input  logic              wr,
   input  logic [addr_w-1:0] a,
   input  logic [line_w-1:0] write_data,
   output logic [line_w-1:0] read_data,
   output logic              rdy,
   // Arbiter side
   output logic              br,
   input  logic              bg,
   // Shared bus
   output bus_cmd_e          cmd,
   output logic [addr_w-1:0] addr,
   output logic [bus_w-1:0]  wdata,
   input  logic [bus_w-1:0]  bus_rdata,
   input  logic              bus_ack
);

   localparam int cnt_w = $clog2(beats);

   typedef enum logic [2:0] {
      c_idle,
      c_req,
      c_addr,
      c_data,
      c_done
   } cache_state_e;

   cache_state_e state;

   // Captured request
   logic              wr_q;
   logic [addr_w-1:0] a_q;
   // Write words shift out at the bottom, read words shift in at the top
   logic [line_w-1:0] line_q;
   logic [cnt_w-1:0]  beat_cnt;
   // Beat accepted by the slave while we own the bus
   logic              beat_ok;
   logic              last_beat;

   assign beat_ok   = bus_ack && bg && (state == c_data);
   assign last_beat = beat_ok && (beat_cnt == cnt_w'(beats - 1));

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= c_idle;
         wr_q     <= 1'b0;
         beat_cnt <= '0;
      end else begin
         case (state)
            c_idle: begin
               if (en) begin
                  wr_q  <= wr;
                  state <= c_req;
               end
            end
            // Waiting for grant
            c_req: begin
               if (bg) begin
                  state <= c_addr;
               end
            end
            c_addr: begin
               beat_cnt <= '0;
               state    <= c_data;
            end
            c_data: begin
               if (beat_ok) begin
                  beat_cnt <= beat_cnt + 1'b1;
               end
               if (last_beat) begin
                  state <= c_done;
               end
            end
            // One cycle of rdy
            c_done: state <= c_idle;
            default: state <= c_idle;
         endcase
      end
   end

   // Line data path
   always_ff @(posedge bus_clk) begin
      if (state == c_idle && en) begin
         a_q    <= a;
         line_q <= write_data;
      end else if (beat_ok) begin
         line_q <= {bus_rdata, line_q[line_w-1:bus_w]};
      end
      // Read result only changes when a read completes
      if (last_beat && !wr_q) begin
         read_data <= {bus_rdata, line_q[line_w-1:bus_w]};
      end
   end

   // Request held through address and data phases
   assign br  = (state == c_req) || (state == c_addr) || (state == c_data);
   assign rdy = (state == c_done);

   always_comb begin
      if (state == c_addr || state == c_data) begin
         cmd = wr_q ? bus_write : bus_read;
      end else begin
         cmd = bus_idle;
      end
   end

   assign addr  = a_q;
   // Lowest word not yet sent
   assign wdata = line_q[bus_w-1:0];

endmodule

`default_nettype wire

// ==== source/mem_bus_port.sv ====
`default_nettype none

module mem_bus_port
   import bus_pkg::*;
#(
   parameter int  mem_lines = 256,
   localparam int idx_w     = $clog2(mem_lines)
) (
   input  logic              bus_clk,
   input  logic              rst_n,
   // Shared bus, slave side
   input  bus_cmd_e          bus_cmd,
   input  logic [addr_w-1:0] bus_addr,
   input  logic [bus_w-1:0]  bus_wdata,
   output logic [bus_w-1:0]  bus_rdata,
   output logic              bus_ack,
   // Main memory
   output logic              mem_en,
   output logic              mem_wr,
   output logic [idx_w-1:0]  mem_a,
   output logic [line_w-1:0] mem_wdata,
   input  logic [line_w-1:0] mem_rdata
);

   localparam int cnt_w = $clog2(beats);

   typedef enum logic [2:0] {
      m_idle,
      m_wbeat,
      m_write,
      m_read,
      m_rbeat
   } mem_state_e;

   mem_state_e state;

   logic [cnt_w-1:0]  beat_cnt;
   logic              last_cnt;
   // Memory index, upper address bits dropped
   logic [idx_w-1:0]  a_q;
   // Write line under assembly
   logic [line_w-1:0] line_q;

   assign last_cnt = (beat_cnt == cnt_w'(beats - 1));

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= m_idle;
         beat_cnt <= '0;
      end else begin
         case (state)
            // Address phase
            m_idle: begin
               beat_cnt <= '0;
               if (bus_cmd == bus_write) begin
                  state <= m_wbeat;
               end else if (bus_cmd == bus_read) begin
                  state <= m_read;
               end
            end
            m_wbeat: begin
               beat_cnt <= beat_cnt + 1'b1;
               if (last_cnt) begin
                  state <= m_write;
               end
            end
            m_write: state <= m_idle;
            // Line arrives at the end of this cycle
            m_read: state <= m_rbeat;
            m_rbeat: begin
               beat_cnt <= beat_cnt + 1'b1;
               if (last_cnt) begin
                  state <= m_idle;
               end
            end
            default: state <= m_idle;
         endcase
      end
   end

   always_ff @(posedge bus_clk) begin
      if (state == m_idle && bus_cmd != bus_idle) begin
         a_q <= bus_addr[idx_w-1:0];
      end
      // Least significant word first
      if (state == m_wbeat) begin
         line_q <= {bus_wdata, line_q[line_w-1:bus_w]};
      end
   end

   // One ack per beat in either direction
   assign bus_ack   = (state == m_wbeat) || (state == m_rbeat);
   assign bus_rdata = (state == m_rbeat) ? mem_rdata[bus_w*beat_cnt +: bus_w] : '0;

   assign mem_en    = (state == m_write) || (state == m_read);
   assign mem_wr    = (state == m_write);
   assign mem_a     = a_q;
   assign mem_wdata = line_q;

endmodule

`default_nettype wire

// ==== source/main_memory.sv ====
`default_nettype none

module main_memory
   import bus_pkg::*;
#(
   parameter int  mem_lines = 256,
   localparam int idx_w     = $clog2(mem_lines)
) (
   input  logic              bus_clk,
   input  logic              mem_en,
   input  logic              mem_wr,
   input  logic [idx_w-1:0]  mem_a,
   input  logic [line_w-1:0] mem_wdata,
   output logic [line_w-1:0] mem_rdata
);

   // One full cache line per entry
   logic [line_w-1:0] lines [mem_lines];

   always_ff @(posedge bus_clk) begin
      if (mem_en) begin
         if (mem_wr) begin
            lines[mem_a] <= mem_wdata;
         end else begin
            // Registered read, held until the next read
            mem_rdata <= lines[mem_a];
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/full_memory.sv ====
`default_nettype none

module full_memory
   import bus_pkg::*;
#(
   parameter int  mem_lines = 256,
   localparam int idx_w     = $clog2(mem_lines)
) (
   input  logic              bus_clk,
   input  logic              rst_n,
   // dcache side
   input  logic              dc_en,
   input  logic              dc_wr,
   input  logic [addr_w-1:0] dc_a,
   input  logic [line_w-1:0] dc_write_data,
   output logic [line_w-1:0] dc_read_data,
   output logic              dc_rdy,
   // icache side
   input  logic              ic_en,
   input  logic              ic_wr,
   input  logic [addr_w-1:0] ic_a,
   input  logic [line_w-1:0] ic_write_data,
   output logic [line_w-1:0] ic_read_data,
   output logic              ic_rdy
);

   // Arbitration, bit 0 icache and bit 1 dcache
   logic [1:0]        br;
   logic [1:0]        bg;

   // Per-port master outputs
   bus_cmd_e          ic_cmd;
   bus_cmd_e          dc_cmd;
   logic [addr_w-1:0] ic_addr;
   logic [addr_w-1:0] dc_addr;
   logic [bus_w-1:0]  ic_wdata;
   logic [bus_w-1:0]  dc_wdata;

   // The shared bus
   bus_cmd_e          bus_cmd;
   logic [addr_w-1:0] bus_addr;
   logic [bus_w-1:0]  bus_wdata;
   logic [bus_w-1:0]  bus_rdata;
   logic              bus_ack;

   // Controller to memory array
   logic              mem_en;
   logic              mem_wr;
   logic [idx_w-1:0]  mem_a;
   logic [line_w-1:0] mem_wdata;
   logic [line_w-1:0] mem_rdata;

   cache_bus_port icache_port_i (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .en         (ic_en),
      .wr         (ic_wr),
      .a          (ic_a),
      .write_data (ic_write_data),
      .read_data  (ic_read_data),
      .rdy        (ic_rdy),
      .br         (br[0]),
      .bg         (bg[0]),
      .cmd        (ic_cmd),
      .addr       (ic_addr),
      .wdata      (ic_wdata),
      .bus_rdata  (bus_rdata),
      .bus_ack    (bus_ack)
   );

   cache_bus_port dcache_port_i (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .en         (dc_en),
      .wr         (dc_wr),
      .a          (dc_a),
      .write_data (dc_write_data),
      .read_data  (dc_read_data),
      .rdy        (dc_rdy),
      .br         (br[1]),
      .bg         (bg[1]),
      .cmd        (dc_cmd),
      .addr       (dc_addr),
      .wdata      (dc_wdata),
      .bus_rdata  (bus_rdata),
      .bus_ack    (bus_ack)
   );

   bus_arbiter arbiter_i (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .br        (br),
      .bg        (bg),
      .ic_cmd    (ic_cmd),
      .dc_cmd    (dc_cmd),
      .ic_addr   (ic_addr),
      .dc_addr   (dc_addr),
      .ic_wdata  (ic_wdata),
      .dc_wdata  (dc_wdata),
      .bus_cmd   (bus_cmd),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata)
   );

   // Memory bus controller, the only slave
   mem_bus_port #(
      .mem_lines (mem_lines)
   ) mem_port_i (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .bus_cmd   (bus_cmd),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_rdata (bus_rdata),
      .bus_ack   (bus_ack),
      .mem_en    (mem_en),
      .mem_wr    (mem_wr),
      .mem_a     (mem_a),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   main_memory #(
      .mem_lines (mem_lines)
   ) memory_i (
      .bus_clk   (bus_clk),
      .mem_en    (mem_en),
      .mem_wr    (mem_wr),
      .mem_a     (mem_a),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// ==== sim/full_memory_tb.sv ====
`default_nettype none

module full_memory_tb
   import bus_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int mem_lines = 256;
   localparam int num_tests = 13;
   // Port selection in the table
   localparam int p_ic      = 0;
   localparam int p_dc      = 1;
   localparam int p_both    = 2;

   logic              bus_clk = 1'b0;
   logic              rst_n;
   logic              dc_en;
   logic              dc_wr;
   logic [addr_w-1:0] dc_a;
   logic [line_w-1:0] dc_write_data;
   logic [line_w-1:0] dc_read_data;
   logic              dc_rdy;
   logic              ic_en;
   logic              ic_wr;
   logic [addr_w-1:0] ic_a;
   logic [line_w-1:0] ic_write_data;
   logic [line_w-1:0] ic_read_data;
   logic              ic_rdy;

   // Stimulus table, a2 and data2 only used when both ports run
   string             t_name  [num_tests];
   int                t_port  [num_tests];
   logic              t_wr    [num_tests];
   logic [addr_w-1:0] t_a     [num_tests];
   logic [addr_w-1:0] t_a2    [num_tests];
   logic [line_w-1:0] t_data  [num_tests];
   logic [line_w-1:0] t_data2 [num_tests];
   int                n_tests = 0;

   // Reference memory, keyed by line index
   logic [line_w-1:0] ref_mem [int];

   integer            seed = 29;
   int                cycle_cnt = 0;
   int                mismatch_cnt = 0;
   int                fail_cnt = 0;

   full_memory #(
      .mem_lines (mem_lines)
   ) dut_i (
      .bus_clk       (bus_clk),
      .rst_n         (rst_n),
      .dc_en         (dc_en),
      .dc_wr         (dc_wr),
      .dc_a          (dc_a),
      .dc_write_data (dc_write_data),
      .dc_read_data  (dc_read_data),
      .dc_rdy        (dc_rdy),
      .ic_en         (ic_en),
      .ic_wr         (ic_wr),
      .ic_a          (ic_a),
      .ic_write_data (ic_write_data),
      .ic_read_data  (ic_read_data),
      .ic_rdy        (ic_rdy)
   );

   // 40 ns period
   always #20 bus_clk = ~bus_clk;

   always @(posedge bus_clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // Upper address bits alias onto the same line
   function automatic int key_of(input logic [addr_w-1:0] a);
      return int'(a) % mem_lines;
   endfunction

   function automatic logic [line_w-1:0] rand_line();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   task automatic add_test(input string name, input int port, input logic wr,
                           input logic [addr_w-1:0] a, input logic [addr_w-1:0] a2);
      t_name[n_tests]  = name;
      t_port[n_tests]  = port;
      t_wr[n_tests]    = wr;
      t_a[n_tests]     = a;
      t_a2[n_tests]    = a2;
      t_data[n_tests]  = rand_line();
      t_data2[n_tests] = rand_line();
      n_tests++;
   endtask

   task automatic check_line(input string name, input logic [line_w-1:0] exp,
                             input logic [line_w-1:0] act);
      if (act !== exp) begin
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_latency(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("mismatch %s: expected %0d cycles, actual %0d cycles", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("mismatch %s: expected %b, actual %b", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   // One line transfer on one port, entered 1 ns after a rising edge
   task automatic transfer(input string name, input bit use_dc, input logic wr,
                           input logic [addr_w-1:0] a, input logic [line_w-1:0] data,
                           output logic [line_w-1:0] rd_line, output int cycles);
      int   start;
      logic seen;
      start = cycle_cnt;
      if (use_dc) begin
         dc_wr         = wr;
         dc_a          = a;
         dc_write_data = data;
         dc_en         = 1'b1;
      end else begin
         ic_wr         = wr;
         ic_a          = a;
         ic_write_data = data;
         ic_en         = 1'b1;
      end
      seen = 1'b0;
      // Watchdog covers a missing rdy
      while (!seen) begin
         @(posedge bus_clk);
         #1;
         seen = use_dc ? dc_rdy : ic_rdy;
      end
      cycles  = cycle_cnt - start;
      rd_line = use_dc ? dc_read_data : ic_read_data;
      if (use_dc) begin
         dc_en = 1'b0;
      end else begin
         ic_en = 1'b0;
      end
      // rdy is a single-cycle pulse
      @(posedge bus_clk);
      #1;
      check_bit({name, "_rdy_pulse"}, 1'b0, use_dc ? dc_rdy : ic_rdy);
   endtask

   // Forty cycles per entry, one extra slot for reset
   initial begin
      #((num_tests + 1) * 40 * 40);
      $display("timeout: a transaction never completed");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      logic [line_w-1:0] line_a;
      logic [line_w-1:0] line_b;
      int                cyc_a;
      int                cyc_b;
      int                exp_lat;
      int                early;
      int                late;
      logic              exp_dc_first;
      logic              dc_first;
      // Reset leaves the arbiter as if dcache owned the bus
      logic              last_dc;
      last_dc       = 1'b1;
      rst_n         = 1'b0;
      dc_en         = 1'b0;
      dc_wr         = 1'b0;
      dc_a          = '0;
      dc_write_data = '0;
      ic_en         = 1'b0;
      ic_wr         = 1'b0;
      ic_a          = '0;
      ic_write_data = '0;

      add_test("dc_write_a",        p_dc,   1'b1, 16'h0010, 16'h0000);
      add_test("dc_read_a",         p_dc,   1'b0, 16'h0010, 16'h0000);
      add_test("ic_read_shared",    p_ic,   1'b0, 16'h0010, 16'h0000);
      add_test("ic_write_b",        p_ic,   1'b1, 16'h0020, 16'h0000);
      add_test("dc_read_b",         p_dc,   1'b0, 16'h0020, 16'h0000);
      add_test("both_write",        p_both, 1'b1, 16'h0030, 16'h0041);
      add_test("both_read",         p_both, 1'b0, 16'h0030, 16'h0041);
      add_test("ic_read_c",         p_ic,   1'b0, 16'h0041, 16'h0000);
      // Round robin, dcache wins after an icache transfer
      add_test("both_read_rr",      p_both, 1'b0, 16'h0010, 16'h0020);
      add_test("dc_write_alias",    p_dc,   1'b1, 16'h0110, 16'h0000);
      add_test("ic_read_alias",     p_ic,   1'b0, 16'h0010, 16'h0000);
      add_test("dc_write_alias_hi", p_dc,   1'b1, 16'hff20, 16'h0000);
      add_test("dc_read_alias_lo",  p_dc,   1'b0, 16'h0020, 16'h0000);

      repeat (5) @(posedge bus_clk);
      check_bit("reset_ic_rdy", 1'b0, ic_rdy);
      check_bit("reset_dc_rdy", 1'b0, dc_rdy);
      #1;
      rst_n = 1'b1;
      // No request yet, so no rdy
      repeat (3) begin
         @(posedge bus_clk);
         #1;
         check_bit("idle_ic_rdy", 1'b0, ic_rdy);
         check_bit("idle_dc_rdy", 1'b0, dc_rdy);
      end

      for (int i = 0; i < n_tests; i++) begin
         exp_lat = t_wr[i] ? 8 : 9;
         if (t_port[i] == p_both) begin
            // Port that did not own the bus last goes first
            exp_dc_first = !last_dc;
            fork
               transfer(t_name[i], 1'b0, t_wr[i], t_a[i], t_data[i], line_a, cyc_a);
               transfer(t_name[i], 1'b1, t_wr[i], t_a2[i], t_data2[i], line_b, cyc_b);
            join
            // Both started in the same cycle
            dc_first = (cyc_b < cyc_a);
            check_bit({t_name[i], "_dc_first"}, exp_dc_first, dc_first);
            early = dc_first ? cyc_b : cyc_a;
            late  = dc_first ? cyc_a : cyc_b;
            check_latency({t_name[i], "_first"}, exp_lat, early);
            // Grant moves one cycle after the first rdy
            // Waiting port then needs a whole transfer less capture and arbitration
            if (late - early < exp_lat - 1) begin
               $display("%s: second port finished only %0d cycles after the first",
                        t_name[i], late - early);
               fail_cnt++;
            end
            last_dc = !exp_dc_first;
            if (t_wr[i]) begin
               ref_mem[key_of(t_a[i])]  = t_data[i];
               ref_mem[key_of(t_a2[i])] = t_data2[i];
            end else begin
               check_line({t_name[i], "_ic"}, ref_mem[key_of(t_a[i])], line_a);
               check_line({t_name[i], "_dc"}, ref_mem[key_of(t_a2[i])], line_b);
            end
         end else begin
            transfer(t_name[i], t_port[i] == p_dc, t_wr[i], t_a[i], t_data[i],
                     line_a, cyc_a);
            check_latency(t_name[i], exp_lat, cyc_a);
            last_dc = (t_port[i] == p_dc);
            if (t_wr[i]) begin
               ref_mem[key_of(t_a[i])] = t_data[i];
            end else begin
               check_line(t_name[i], ref_mem[key_of(t_a[i])], line_a);
            end
         end
      end

      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt + fail_cnt == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== full_memory.f ====
source/bus_pkg.sv
source/bus_arbiter.sv
source/cache_bus_port.sv
source/mem_bus_port.sv
source/main_memory.sv
source/full_memory.sv
sim/full_memory_tb.sv
